// File: hw/cci_read_pkg.sv
package cci_read_pkg;

   // Cache-line address as carried on the tx0 read channel
   typedef logic [31:0] t_cl_addr;

   // Identifies which internal client raised a read request
   typedef logic [1:0] t_src_id;

   // Number of clients that share the read channel
   localparam int NUM_SRC = 3;

   // Client codes, also placed in the top bits of the request metadata
   localparam t_src_id SRC_READER = 2'd0;
   localparam t_src_id SRC_WRITER = 2'd1;
   localparam t_src_id SRC_STATUS = 2'd2;

   // Per-client sequence number, wraps modulo 256
   typedef logic [7:0] t_seq;

   // Request metadata returned by the host with the read response
   // Layout from the top is source, zero padding, then sequence number
   typedef logic [15:0] t_mdata;

   // Width of the zero field between source and sequence number
   localparam int MDATA_PAD_W = $bits(t_mdata) - $bits(t_src_id) - $bits(t_seq);

   // Command code on tx0
   typedef logic [3:0] t_req_type;

   // Read a full cache line, the only command this path issues
   localparam t_req_type REQ_RDLINE = 4'h4;

   // Issue controller states
   // The link must train first, then the host back-pressure level
   // decides between running and holding off
   typedef enum logic [1:0] {
      ISSUE_WAIT_INIT,
      ISSUE_RUN,
      ISSUE_FULL
   } t_issue_state;

   // Arbiter fairness state between frame reader and frame writer
   typedef enum logic {
      FAVOR_FRAME_READER,
      FAVOR_FRAME_WRITER
   } t_favor;

endpackage

// File: hw/cci_can_issue.sv
`timescale 1ns/100ps

module cci_can_issue import cci_read_pkg::*; (
   input  logic clk,
   input  logic resetb,
   input  logic lp_initdone,
   input  logic almostfull,
   input  logic issue,
   output logic can_issue
);

   t_issue_state state;
   t_issue_state next_state;

   // Next state follows the sampled link and back-pressure levels
   always_comb begin
      next_state = state;
      case (state)
         ISSUE_WAIT_INIT: begin
            // Nothing may go out before link training completes
            if (lp_initdone) begin
               next_state = almostfull ? ISSUE_FULL : ISSUE_RUN;
            end
         end
         ISSUE_RUN: begin
            // Host reports its queue nearly full, so stop issuing
            if (almostfull) begin
               next_state = ISSUE_FULL;
            end
         end
         ISSUE_FULL: begin
            // Resume once back-pressure has been released
            if (!almostfull) begin
               next_state = ISSUE_RUN;
            end
         end
         default: begin
            next_state = ISSUE_WAIT_INIT;
         end
      endcase
   end

   // State register
   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= ISSUE_WAIT_INIT;
      end else begin
         state <= next_state;
      end
   end

   // Permission is registered from the next state
   // This gives one cycle from the sampled input to the permission change
   always_ff @(posedge clk) begin
      if (!resetb) begin
         can_issue <= 1'b0;
      end else begin
         can_issue <= (next_state == ISSUE_RUN);
      end
   end

   // The arbiter must never grant while this block withholds permission
   a_no_issue_blocked : assert property (
      @(posedge clk) disable iff (!resetb)
      issue |-> can_issue
   ) else $error("Read issued while can_issue is low");

endmodule

// File: hw/cci_read_arbiter.sv
`timescale 1ns/100ps

module cci_read_arbiter import cci_read_pkg::*; (
   input  logic     clk,
   input  logic     resetb,
   input  logic     can_issue,
   input  logic     afu_en,
   input  logic     reader_req,
   input  t_cl_addr reader_addr,
   input  logic     writer_req,
   input  t_cl_addr writer_addr,
   input  logic     status_req,
   input  t_cl_addr status_addr,
   output logic     reader_grant,
   output logic     writer_grant,
   output logic     status_grant,
   output logic     issue,
   output logic     sel_valid,
   output t_src_id  sel_src,
   output t_cl_addr sel_addr
);

   // Traffic is allowed only when the link is ready and software enabled us
   logic permit;

   t_favor state;
   t_favor next_state;

   assign permit = can_issue && afu_en;

   // Pick a winner and steer its address toward the output stage
   always_comb begin
      reader_grant = 1'b0;
      writer_grant = 1'b0;
      status_grant = 1'b0;

      // Default to the reader path so the address mux stays small
      sel_src  = SRC_READER;
      sel_addr = reader_addr;

      if (reader_req && (state == FAVOR_FRAME_READER || !writer_req)) begin
         // Reader wins on its turn, or any time the writer is idle
         reader_grant = permit;
      end else if (writer_req) begin
         sel_src      = SRC_WRITER;
         sel_addr     = writer_addr;
         writer_grant = permit;
      end else if (status_req) begin
         // Status traffic only gets the slot that both frame clients leave
         sel_src      = SRC_STATUS;
         sel_addr     = status_addr;
         status_grant = permit;
      end
   end

   // Any grant is one read going out on tx0
   assign issue     = reader_grant || writer_grant || status_grant;
   assign sel_valid = issue;

   // After serving the reader, the writer gets the next turn
   always_comb begin
      if (reader_grant) begin
         next_state = FAVOR_FRAME_WRITER;
      end else begin
         next_state = FAVOR_FRAME_READER;
      end
   end

   // Fairness state register
   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= FAVOR_FRAME_READER;
      end else begin
         state <= next_state;
      end
   end

   // At most one client is granted in any cycle
   a_grant_onehot : assert property (
      @(posedge clk) disable iff (!resetb)
      $onehot0({reader_grant, writer_grant, status_grant})
   ) else $error("More than one read grant in a cycle");

endmodule

// File: hw/cci_tx0_header.sv
`timescale 1ns/100ps

module cci_tx0_header import cci_read_pkg::*; (
   input  logic      clk,
   input  logic      resetb,
   input  logic      sel_valid,
   input  t_src_id   sel_src,
   input  t_cl_addr  sel_addr,
   output logic      tx0_rdvalid,
   output t_req_type tx0_req_type,
   output t_cl_addr  tx0_addr,
   output t_mdata    tx0_mdata
);

   // One running sequence number per client
   t_seq seq_cnt [NUM_SRC];

   // Sequence number of the client selected this cycle
   t_seq cur_seq;

   // Metadata for the request being registered
   t_mdata mdata;

   // Look up the sequence number of the selected client
   always_comb begin
      case (sel_src)
         SRC_READER: cur_seq = seq_cnt[0];
         SRC_WRITER: cur_seq = seq_cnt[1];
         SRC_STATUS: cur_seq = seq_cnt[2];
         default:    cur_seq = '0;
      endcase
   end

   // Source goes in the top bits so responses can be routed back
   assign mdata = {sel_src, {MDATA_PAD_W{1'b0}}, cur_seq};

   // Each counter advances only when its own client is sent
   always_ff @(posedge clk) begin
      if (!resetb) begin
         for (int i = 0; i < NUM_SRC; i++) begin
            seq_cnt[i] <= '0;
         end
      end else if (sel_valid) begin
         for (int i = 0; i < NUM_SRC; i++) begin
            if (sel_src == t_src_id'(i)) begin
               seq_cnt[i] <= seq_cnt[i] + 1'b1;
            end
         end
      end
   end

   // Valid bit is held low through reset
   always_ff @(posedge clk) begin
      if (!resetb) begin
         tx0_rdvalid <= 1'b0;
      end else begin
         tx0_rdvalid <= sel_valid;
      end
   end

   // Header fields load only with a valid selection
   always_ff @(posedge clk) begin
      if (sel_valid) begin
         tx0_req_type <= REQ_RDLINE;
         tx0_addr     <= sel_addr;
         tx0_mdata    <= mdata;
      end
   end

   // Source code 3 has no client behind it
   a_src_legal : assert property (
      @(posedge clk) disable iff (!resetb)
      sel_valid |-> (sel_src != 2'd3)
   ) else $error("Selection from unknown source %0d", sel_src);

endmodule

// File: hw/cci_read_top.sv
`timescale 1ns/100ps

module cci_read_top import cci_read_pkg::*; (
   input  logic      clk,
   input  logic      resetb,
   input  logic      lp_initdone,
   input  logic      afu_en,
   input  logic      tx0_almostfull,
   input  logic      reader_req,
   input  t_cl_addr  reader_addr,
   input  logic      writer_req,
   input  t_cl_addr  writer_addr,
   input  logic      status_req,
   input  t_cl_addr  status_addr,
   output logic      reader_grant,
   output logic      writer_grant,
   output logic      status_grant,
   output logic      tx0_rdvalid,
   output t_req_type tx0_req_type,
   output t_cl_addr  tx0_addr,
   output t_mdata    tx0_mdata
);

   // Link readiness from the issue controller
   logic can_issue;

   // Single pulse for any grant, checked by the issue controller
   logic issue;

   // Winning request handed to the output stage
   logic     sel_valid;
   t_src_id  sel_src;
   t_cl_addr sel_addr;

   // Tracks link training and host back-pressure
   cci_can_issue u_can_issue (
      .clk         (clk),
      .resetb      (resetb),
      .lp_initdone (lp_initdone),
      .almostfull  (tx0_almostfull),
      .issue       (issue),
      .can_issue   (can_issue)
   );

   // Chooses one of the three clients each cycle
   cci_read_arbiter u_arbiter (
      .clk          (clk),
      .resetb       (resetb),
      .can_issue    (can_issue),
      .afu_en       (afu_en),
      .reader_req   (reader_req),
      .reader_addr  (reader_addr),
      .writer_req   (writer_req),
      .writer_addr  (writer_addr),
      .status_req   (status_req),
      .status_addr  (status_addr),
      .reader_grant (reader_grant),
      .writer_grant (writer_grant),
      .status_grant (status_grant),
      .issue        (issue),
      .sel_valid    (sel_valid),
      .sel_src      (sel_src),
      .sel_addr     (sel_addr)
   );

   // Stamps command and metadata, then registers onto tx0
   cci_tx0_header u_tx0_header (
      .clk          (clk),
      .resetb       (resetb),
      .sel_valid    (sel_valid),
      .sel_src      (sel_src),
      .sel_addr     (sel_addr),
      .tx0_rdvalid  (tx0_rdvalid),
      .tx0_req_type (tx0_req_type),
      .tx0_addr     (tx0_addr),
      .tx0_mdata    (tx0_mdata)
   );

endmodule

// File: testbench/tb_cci_read.sv
`timescale 1ns/100ps

module tb_cci_read;

   // Command code that every tx0 read must carry
   localparam logic [3:0] EXP_RDLINE = 4'h4;
   localparam int NUM_PHASES = 11;
   localparam int DRAIN_TIMEOUT = 50;
   // Time from the falling edge until the combinational grants are looked at
   localparam int SETTLE_NS = 5;

   // One row of the stimulus table
   typedef struct packed {
      logic        rd_on;
      logic        wr_on;
      logic        st_on;
      logic        en;
      logic        af;
      logic        init;
      logic [15:0] cycles;
   } phase_t;

   phase_t phase_tab [NUM_PHASES];

   logic        clk;
   logic        resetb;
   logic        lp_initdone;
   logic        afu_en;
   logic        tx0_almostfull;
   logic        cl_req [3];
   logic [31:0] cl_addr [3];
   logic        cl_on [3];
   wire  [2:0]  grant;
   wire         tx0_rdvalid;
   wire  [3:0]  tx0_req_type;
   wire  [31:0] tx0_addr;
   wire  [15:0] tx0_mdata;

   // Reference model state where index 0 is the reader, 1 the writer and 2 the status manager
   logic        model_can;
   logic        init_seen;
   logic        favor_wr;
   logic        prev_valid;
   logic [1:0]  prev_src;
   logic [7:0]  exp_seq [3];
   int          served [3];
   logic [31:0] rd_q [$];
   logic [31:0] wr_q [$];
   logic [31:0] st_q [$];
   logic [31:0] lcg_state;
   int          err_count;

   cci_read_top DUT (
      .clk            (clk),
      .resetb         (resetb),
      .lp_initdone    (lp_initdone),
      .afu_en         (afu_en),
      .tx0_almostfull (tx0_almostfull),
      .reader_req     (cl_req[0]),
      .reader_addr    (cl_addr[0]),
      .writer_req     (cl_req[1]),
      .writer_addr    (cl_addr[1]),
      .status_req     (cl_req[2]),
      .status_addr    (cl_addr[2]),
      .reader_grant   (grant[0]),
      .writer_grant   (grant[1]),
      .status_grant   (grant[2]),
      .tx0_rdvalid    (tx0_rdvalid),
      .tx0_req_type   (tx0_req_type),
      .tx0_addr       (tx0_addr),
      .tx0_mdata      (tx0_mdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Grant vector that the arbitration rules call for this cycle
   function automatic logic [2:0] expected_grant();
      if (!(model_can && afu_en)) return 3'b000;
      // Reader on its turn, or whenever the writer is idle
      if (cl_req[0] && (!favor_wr || !cl_req[1])) return 3'b001;
      if (cl_req[1]) return 3'b010;
      if (cl_req[2]) return 3'b100;
      return 3'b000;
   endfunction

   task automatic report_mismatch(input string msg);
      err_count++;
      $display("mismatch at %0t ns: %s", $time, msg);
      $display("Errors found");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic report_failure(input string msg);
      err_count++;
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic pop_expected(input logic [1:0] src, output logic [31:0] addr);
      addr = '0;
      case (src)
         2'd0: if (rd_q.size() > 0) addr = rd_q.pop_front();
         2'd1: if (wr_q.size() > 0) addr = wr_q.pop_front();
         default: if (st_q.size() > 0) addr = st_q.pop_front();
      endcase
   endtask

   // tx0 must mirror the grant of the previous cycle
   task automatic check_tx0();
      logic [1:0]  src;
      logic [31:0] exp_addr;
      assert (tx0_rdvalid == prev_valid) else report_mismatch($sformatf(
         "tx0_rdvalid %0b, expected %0b", tx0_rdvalid, prev_valid));
      if (tx0_rdvalid) begin
         src = tx0_mdata[15:14];
         assert (src == prev_src) else report_mismatch($sformatf(
            "tx0 source %0d, expected %0d", src, prev_src));
         pop_expected(src, exp_addr);
         assert (tx0_req_type == EXP_RDLINE) else report_mismatch($sformatf(
            "tx0_req_type %0h, expected %0h", tx0_req_type, EXP_RDLINE));
         assert (tx0_addr == exp_addr) else report_mismatch($sformatf(
            "tx0_addr %h, expected %h for source %0d", tx0_addr, exp_addr, src));
         assert (tx0_mdata[13:8] == 6'd0) else report_mismatch($sformatf(
            "tx0_mdata pad field %h is not zero", tx0_mdata[13:8]));
         assert (tx0_mdata[7:0] == exp_seq[src]) else report_mismatch($sformatf(
            "sequence %0d, expected %0d for source %0d", tx0_mdata[7:0], exp_seq[src], src));
         exp_seq[src] = exp_seq[src] + 8'd1;
         served[src]++;
      end
   endtask

   // Compare grants with the model, then move granted requests into the queues
   task automatic check_grants();
      logic [2:0] exp_g;
      exp_g = expected_grant();
      assert (grant == exp_g) else report_mismatch($sformatf(
         "grants %b, expected %b", grant, exp_g));
      assert (!(grant[2] && (cl_req[0] || cl_req[1]))) else report_mismatch(
         "status manager granted while a frame client requests");
      prev_valid = |grant;
      prev_src = grant[1] ? 2'd1 : (grant[2] ? 2'd2 : 2'd0);
      if (grant[0]) rd_q.push_back(cl_addr[0]);
      if (grant[1]) wr_q.push_back(cl_addr[1]);
      if (grant[2]) st_q.push_back(cl_addr[2]);
      favor_wr = grant[0];
   endtask

   // One clock of the client models and the checks
   // Inputs change on the falling edge and grants are looked at before the rising edge
   task automatic run_cycle(input phase_t ph);
      @(negedge clk);
      check_tx0();
      // The client granted in the last cycle may now move on
      if (prev_valid) begin
         cl_req[prev_src] = 1'b0;
      end
      cl_on[0] = ph.rd_on;
      cl_on[1] = ph.wr_on;
      cl_on[2] = ph.st_on;
      // An idle client that is switched on presents a fresh address at once
      for (int i = 0; i < 3; i++) begin
         if (!cl_req[i] && cl_on[i]) begin
            lcg_state = lcg_next(lcg_state);
            cl_addr[i] = lcg_state;
            cl_req[i] = 1'b1;
         end
      end
      afu_en = ph.en;
      tx0_almostfull = ph.af;
      lp_initdone = ph.init;
      #(SETTLE_NS);
      check_grants();
      // Permission follows the sampled levels one clock later
      init_seen = init_seen || ph.init;
      model_can = init_seen && !ph.af;
   endtask

   task automatic load_table();
      // rd wr st en af init cycles
      phase_tab[0]  = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 16'd10};
      phase_tab[1]  = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 16'd10};
      phase_tab[2]  = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 16'd40};
      phase_tab[3]  = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 16'd12};
      phase_tab[4]  = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 16'd20};
      phase_tab[5]  = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 16'd20};
      phase_tab[6]  = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 16'd15};
      phase_tab[7]  = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 16'd6};
      phase_tab[8]  = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 16'd15};
      phase_tab[9]  = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 16'd8};
      // Long run wraps the sequence numbers of reader and writer
      phase_tab[10] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 16'd480};
   endtask

   initial begin
      phase_t drain_ph;
      int     wait_cnt;
      resetb = 1'b0;
      lp_initdone = 1'b0;
      afu_en = 1'b0;
      tx0_almostfull = 1'b0;
      for (int i = 0; i < 3; i++) begin
         cl_req[i] = 1'b0;
         cl_addr[i] = '0;
         cl_on[i] = 1'b0;
         exp_seq[i] = '0;
         served[i] = 0;
      end
      model_can = 1'b0;
      init_seen = 1'b0;
      favor_wr = 1'b0;
      prev_valid = 1'b0;
      prev_src = 2'd0;
      lcg_state = 32'h8a6b_219a;
      err_count = 0;
      load_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
      for (int p = 0; p < NUM_PHASES; p++) begin
         for (int c = 0; c < int'(phase_tab[p].cycles); c++) begin
            run_cycle(phase_tab[p]);
         end
      end
      // Clients stop raising new requests but held ones must still go out
      drain_ph = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 16'd0};
      wait_cnt = 0;
      while (cl_req[0] || cl_req[1] || cl_req[2] || prev_valid ||
             rd_q.size() > 0 || wr_q.size() > 0 || st_q.size() > 0) begin
         if (wait_cnt == DRAIN_TIMEOUT) begin
            report_failure("Timeout while waiting for the request queues to drain");
         end
         run_cycle(drain_ph);
         wait_cnt++;
      end
      for (int i = 0; i < 3; i++) begin
         assert (served[i] > 0) else report_failure($sformatf(
            "Client %0d was never served during the run", i));
      end
      if (err_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: vlog.f
hw/cci_read_pkg.sv
hw/cci_can_issue.sv
hw/cci_read_arbiter.sv
hw/cci_tx0_header.sv
hw/cci_read_top.sv
testbench/tb_cci_read.sv

// File: run.sh
#!/bin/sh
# Build the read-path testbench with Verilator, run it, and scan its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_cci_read -o tb_cci_read || { echo "Build failed"; exit 1; }
out="$(./obj_dir/tb_cci_read 2>&1)"
echo "$out"
echo "$out" | grep -q "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }
